//--- source/rom_game_settings.svh
`ifndef ROM_GAME_SETTINGS_SVH
`define ROM_GAME_SETTINGS_SVH

// Download map, byte addresses as seen by the loader
// Main CPU code starts at byte 0
`define SCR_START 'h08000
`define OBJ_START 'h10000
// End of the object graphics, PCM data follows
`define PCM_START 'h20000

// Slot address widths
// Main addresses bytes
`define MAIN_AW 15
// Scroll and objects address 32-bit lines
`define SCR_AW 13
`define OBJ_AW 14

`endif

//--- source/rom_map_pkg.sv
package rom_map_pkg;

    // SDRAM word address, one word is 16 bits
    typedef logic [21:0] sdram_addr_t;

    // Region of a loader byte address
    // MAIN passes straight through
    // SCR and OBJ get their graphics bit scramble
    // OTHER covers PCM and anything past it
    typedef enum logic [1:0] {
        MAIN  = 2'd0,
        SCR   = 2'd1,
        OBJ   = 2'd2,
        OTHER = 2'd3
    } region_e;

endpackage

//--- source/slot_pkg.sv
package slot_pkg;

    // One SDRAM word
    typedef logic [15:0] word_t;

    // Cache line, first word read sits in the low half
    typedef logic [31:0] line_t;

    // Slot payloads
    typedef logic [7:0]  main_data_t;
    typedef logic [31:0] gfx_data_t;

    // Slots in arbitration priority order, also the fill_req bit index
    typedef enum logic [1:0] {
        MAIN = 2'd0,
        OBJ  = 2'd1,
        SCR  = 2'd2
    } slot_e;

endpackage

//--- source/dwnld_remap.sv
`timescale 1ns/1ns
`include "rom_game_settings.svh"

module dwnld_remap (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [24:0]              ioctl_addr,
    input  logic [7:0]               ioctl_dout,
    input  logic                     ioctl_wr,
    input  logic                     sdram_ack,
    output rom_map_pkg::sdram_addr_t prog_addr,
    output logic [7:0]               prog_data,
    output logic [1:0]               prog_mask,
    output logic                     prog_we
);

    localparam logic [24:0] SCR_START = 25'(`SCR_START);
    localparam logic [24:0] OBJ_START = 25'(`OBJ_START);
    localparam logic [24:0] PCM_START = 25'(`PCM_START);

    rom_map_pkg::region_e     region;
    rom_map_pkg::sdram_addr_t base_addr;
    rom_map_pkg::sdram_addr_t remap_addr;

    assign base_addr = ioctl_addr[22:1];

    always_comb begin
        if (ioctl_addr < SCR_START) begin
            region = rom_map_pkg::MAIN;
        end else if (ioctl_addr < OBJ_START) begin
            region = rom_map_pkg::SCR;
        end else if (ioctl_addr < PCM_START) begin
            region = rom_map_pkg::OBJ;
        end else begin
            region = rom_map_pkg::OTHER;
        end
    end

    // Graphics ROMs are stored with their low address bits reordered
    always_comb begin
        remap_addr = base_addr;
        case (region)
            rom_map_pkg::SCR: begin
                remap_addr[0]   = ~base_addr[3];
                remap_addr[3:1] = base_addr[2:0];
            end
            rom_map_pkg::OBJ: begin
                remap_addr[0]   = ~base_addr[3];
                remap_addr[1]   = ~base_addr[4];
                remap_addr[5:2] = {base_addr[5], base_addr[2:0]};
            end
            default: remap_addr = base_addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (prog_we) begin
            if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end else if (ioctl_wr) begin
            prog_we <= 1'b1;
        end
    end

    // Write payload, held while prog_we waits for the ack
    always_ff @(posedge clk) begin
        if (ioctl_wr && !prog_we) begin
            prog_addr <= remap_addr;
            prog_data <= ioctl_dout;
            // Bytes are swapped, so even bytes land in the upper half
            prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
        end
    end

endmodule

//--- source/slot_arbiter.sv
`timescale 1ns/1ns
`include "rom_game_settings.svh"

module slot_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     downloading,
    input  logic [2:0]               fill_req,
    input  logic [`MAIN_AW-3:0]      main_line_addr,
    input  logic [`SCR_AW-1:0]       scr_line_addr,
    input  logic [`OBJ_AW-1:0]       obj_line_addr,
    output logic [2:0]               fill_valid,
    output slot_pkg::line_t          fill_line,
    output logic                     sdram_req,
    input  logic                     sdram_ack,
    output rom_map_pkg::sdram_addr_t sdram_addr,
    input  slot_pkg::word_t          data_read,
    input  logic                     data_rdy
);

    localparam rom_map_pkg::sdram_addr_t SCR_OFFSET = 22'(`SCR_START >> 1);
    localparam rom_map_pkg::sdram_addr_t OBJ_OFFSET = 22'(`OBJ_START >> 1);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        REQUEST = 2'd1,
        COLLECT = 2'd2
    } state_e;

    state_e                   state;
    slot_pkg::slot_e          grant;
    logic                     word_cnt;
    slot_pkg::word_t          low_word;
    logic [2:0]               pending;
    slot_pkg::slot_e          next_slot;
    rom_map_pkg::sdram_addr_t next_addr;

    // A slot that just got its line still shows fill_req for this cycle
    assign pending = fill_req & ~fill_valid;

    always_comb begin
        if (pending[slot_pkg::MAIN]) begin
            next_slot = slot_pkg::MAIN;
            next_addr = rom_map_pkg::sdram_addr_t'({main_line_addr, 1'b0});
        end else if (pending[slot_pkg::OBJ]) begin
            next_slot = slot_pkg::OBJ;
            next_addr = OBJ_OFFSET + rom_map_pkg::sdram_addr_t'({obj_line_addr, 1'b0});
        end else begin
            next_slot = slot_pkg::SCR;
            next_addr = SCR_OFFSET + rom_map_pkg::sdram_addr_t'({scr_line_addr, 1'b0});
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            sdram_req  <= 1'b0;
            fill_valid <= 3'b000;
            word_cnt   <= 1'b0;
        end else begin
            fill_valid <= 3'b000;
            case (state)
                IDLE: begin
                    if (!downloading && |pending) begin
                        state     <= REQUEST;
                        sdram_req <= 1'b1;
                    end
                end
                REQUEST: begin
                    if (sdram_ack) begin
                        state     <= COLLECT;
                        sdram_req <= 1'b0;
                        word_cnt  <= 1'b0;
                    end
                end
                COLLECT: begin
                    if (data_rdy) begin
                        word_cnt <= ~word_cnt;
                        if (word_cnt) begin
                            fill_valid[grant] <= 1'b1;
                            state             <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Grant, address and line data
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            grant      <= next_slot;
            sdram_addr <= next_addr;
        end
        if (state == COLLECT && data_rdy) begin
            if (word_cnt) begin
                fill_line <= {data_read, low_word};
            end else begin
                low_word <= data_read;
            end
        end
    end

endmodule

//--- source/slot_cache.sv
`timescale 1ns/1ns

module slot_cache #(
    parameter type payload_t = slot_pkg::gfx_data_t,
    parameter int  AW        = 13,
    localparam int PAYLOAD_W = $bits(payload_t),
    localparam int LW        = (PAYLOAD_W == 8) ? AW - 2 : AW
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            downloading,
    input  logic            cs,
    input  logic [AW-1:0]   addr,
    output logic            ok,
    output payload_t        dout,
    output logic            fill_req,
    output logic [LW-1:0]   line_addr,
    input  logic            fill_valid,
    input  slot_pkg::line_t fill_line
);

    logic            valid;
    logic [LW-1:0]   tag;
    slot_pkg::line_t line_data;
    logic [LW-1:0]   cur_line;
    logic            hit;

    if (PAYLOAD_W == 8) begin : g_byte
        logic [7:0] byte_sel;

        assign cur_line = addr[AW-1:2];

        // Words are byte swapped inside the line
        always_comb begin
            case (addr[1:0])
                2'd0: byte_sel = line_data[15:8];
                2'd1: byte_sel = line_data[7:0];
                2'd2: byte_sel = line_data[31:24];
                default: byte_sel = line_data[23:16];
            endcase
        end
        assign dout = payload_t'(byte_sel);
    end else begin : g_line
        assign cur_line = addr;
        assign dout     = payload_t'(line_data);
    end

    assign hit = valid && (tag == cur_line);
    assign ok  = cs && hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid    <= 1'b0;
            fill_req <= 1'b0;
        end else begin
            if (fill_valid) begin
                fill_req <= 1'b0;
            end else if (cs && !hit && !fill_req && !downloading) begin
                fill_req <= 1'b1;
            end
            // ROM contents may change while downloading
            if (downloading) begin
                valid <= 1'b0;
            end else if (fill_valid) begin
                valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs && !hit && !fill_req) begin
            line_addr <= cur_line;
        end
        if (fill_valid) begin
            tag       <= line_addr;
            line_data <= fill_line;
        end
    end

endmodule

//--- source/rom_game_top.sv
`timescale 1ns/1ns
`include "rom_game_settings.svh"

module rom_game_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     downloading,
    // Loader
    input  logic [24:0]              ioctl_addr,
    input  logic [7:0]               ioctl_dout,
    input  logic                     ioctl_wr,
    output rom_map_pkg::sdram_addr_t prog_addr,
    output logic [7:0]               prog_data,
    output logic [1:0]               prog_mask,
    output logic                     prog_we,
    // SDRAM
    output logic                     sdram_req,
    input  logic                     sdram_ack,
    output rom_map_pkg::sdram_addr_t sdram_addr,
    input  slot_pkg::word_t          data_read,
    input  logic                     data_rdy,
    // Main CPU ROM
    input  logic                     main_cs,
    input  logic [`MAIN_AW-1:0]      main_addr,
    output logic                     main_ok,
    output slot_pkg::main_data_t     main_data,
    // Scroll ROM
    input  logic                     scr_cs,
    input  logic [`SCR_AW-1:0]       scr_addr,
    output logic                     scr_ok,
    output slot_pkg::gfx_data_t      scr_data,
    // Object ROM
    input  logic                     obj_cs,
    input  logic [`OBJ_AW-1:0]       obj_addr,
    output logic                     obj_ok,
    output slot_pkg::gfx_data_t      obj_data
);

    logic [2:0]             fill_req;
    logic [2:0]             fill_valid;
    slot_pkg::line_t        fill_line;
    logic [`MAIN_AW-3:0]    main_line_addr;
    logic [`SCR_AW-1:0]     scr_line_addr;
    logic [`OBJ_AW-1:0]     obj_line_addr;

    dwnld_remap u_remap (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .ioctl_wr   ( ioctl_wr   ),
        .sdram_ack  ( sdram_ack  ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    )
    );

    // Shares sdram_ack with the remapper, never active at the same time
    slot_arbiter u_arbiter (
        .clk            ( clk            ),
        .rst_n          ( rst_n          ),
        .downloading    ( downloading    ),
        .fill_req       ( fill_req       ),
        .main_line_addr ( main_line_addr ),
        .scr_line_addr  ( scr_line_addr  ),
        .obj_line_addr  ( obj_line_addr  ),
        .fill_valid     ( fill_valid     ),
        .fill_line      ( fill_line      ),
        .sdram_req      ( sdram_req      ),
        .sdram_ack      ( sdram_ack      ),
        .sdram_addr     ( sdram_addr     ),
        .data_read      ( data_read      ),
        .data_rdy       ( data_rdy       )
    );

    slot_cache #(
        .payload_t ( slot_pkg::main_data_t ),
        .AW        ( `MAIN_AW              )
    ) u_main_cache (
        .clk         ( clk                          ),
        .rst_n       ( rst_n                        ),
        .downloading ( downloading                  ),
        .cs          ( main_cs                      ),
        .addr        ( main_addr                    ),
        .ok          ( main_ok                      ),
        .dout        ( main_data                    ),
        .fill_req    ( fill_req[slot_pkg::MAIN]     ),
        .line_addr   ( main_line_addr               ),
        .fill_valid  ( fill_valid[slot_pkg::MAIN]   ),
        .fill_line   ( fill_line                    )
    );

    slot_cache #(
        .payload_t ( slot_pkg::gfx_data_t ),
        .AW        ( `SCR_AW              )
    ) u_scr_cache (
        .clk         ( clk                        ),
        .rst_n       ( rst_n                      ),
        .downloading ( downloading                ),
        .cs          ( scr_cs                     ),
        .addr        ( scr_addr                   ),
        .ok          ( scr_ok                     ),
        .dout        ( scr_data                   ),
        .fill_req    ( fill_req[slot_pkg::SCR]    ),
        .line_addr   ( scr_line_addr              ),
        .fill_valid  ( fill_valid[slot_pkg::SCR]  ),
        .fill_line   ( fill_line                  )
    );

    slot_cache #(
        .payload_t ( slot_pkg::gfx_data_t ),
        .AW        ( `OBJ_AW              )
    ) u_obj_cache (
        .clk         ( clk                        ),
        .rst_n       ( rst_n                      ),
        .downloading ( downloading                ),
        .cs          ( obj_cs                     ),
        .addr        ( obj_addr                   ),
        .ok          ( obj_ok                     ),
        .dout        ( obj_data                   ),
        .fill_req    ( fill_req[slot_pkg::OBJ]    ),
        .line_addr   ( obj_line_addr              ),
        .fill_valid  ( fill_valid[slot_pkg::OBJ]  ),
        .fill_line   ( fill_line                  )
    );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 8 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- dv/sdram_model.sv
`timescale 1ns/1ns

module sdram_model (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rom_map_pkg::sdram_addr_t prog_addr,
    input  logic [7:0]               prog_data,
    input  logic [1:0]               prog_mask,
    input  logic                     prog_we,
    input  logic                     sdram_req,
    input  rom_map_pkg::sdram_addr_t sdram_addr,
    input  logic [1:0]               read_gap,
    output logic                     sdram_ack,
    output slot_pkg::word_t          data_read,
    output logic                     data_rdy
);

    // Covers the main, scroll and object regions
    slot_pkg::word_t mem [0:65535];
    logic [1:0]      phase;
    logic [1:0]      wait_cnt;
    logic [15:0]     rd_addr;

    initial begin
        // Unwritten words hold a pattern of their own address
        for (int i = 0; i < 65536; i++) begin
            mem[i] = {i[7:0], i[15:8]} ^ 16'h5a3c;
        end
        phase     = 2'd0;
        wait_cnt  = 2'd0;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
    end

    // Phase 0 idle, phase 1 low word pending, phase 2 high word pending
    always @(posedge clk) begin
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        if (!rst_n) begin
            phase <= 2'd0;
        end else if (phase == 2'd0) begin
            if (prog_we && !sdram_ack) begin
                // Mask is active low, bit 1 enables the upper byte
                if (prog_addr[21:16] == 6'd0) begin
                    if (!prog_mask[1]) begin
                        mem[prog_addr[15:0]][15:8] <= prog_data;
                    end
                    if (!prog_mask[0]) begin
                        mem[prog_addr[15:0]][7:0] <= prog_data;
                    end
                end
                sdram_ack <= 1'b1;
            end else if (sdram_req && !sdram_ack) begin
                sdram_ack <= 1'b1;
                rd_addr   <= sdram_addr[15:0];
                wait_cnt  <= read_gap;
                phase     <= 2'd1;
            end
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            data_rdy  <= 1'b1;
            data_read <= mem[rd_addr + 16'(phase - 2'd1)];
            wait_cnt  <= read_gap;
            phase     <= (phase == 2'd1) ? 2'd2 : 2'd0;
        end
    end

endmodule

//--- dv/rom_game_tb.sv
`timescale 1ns/1ns
`include "rom_game_settings.svh"

module rom_game_tb;

    localparam int DOWNLOAD_BYTES = 30;
    localparam int READS          = 16;
    localparam int TIMEOUT_CYCLES = DOWNLOAD_BYTES * 6 + READS * 40 + 200;

    logic                     clk;
    logic                     rst_n;
    logic                     downloading;
    logic [24:0]              ioctl_addr;
    logic [7:0]               ioctl_dout;
    logic                     ioctl_wr;
    rom_map_pkg::sdram_addr_t prog_addr;
    logic [7:0]               prog_data;
    logic [1:0]               prog_mask;
    logic                     prog_we;
    logic                     sdram_req;
    logic                     sdram_ack;
    rom_map_pkg::sdram_addr_t sdram_addr;
    slot_pkg::word_t          data_read;
    logic                     data_rdy;
    logic                     main_cs;
    logic [`MAIN_AW-1:0]      main_addr;
    logic                     main_ok;
    slot_pkg::main_data_t     main_data;
    logic                     scr_cs;
    logic [`SCR_AW-1:0]       scr_addr;
    logic                     scr_ok;
    slot_pkg::gfx_data_t      scr_data;
    logic                     obj_cs;
    logic [`OBJ_AW-1:0]       obj_addr;
    logic                     obj_ok;
    slot_pkg::gfx_data_t      obj_data;
    logic [1:0]               read_gap;
    logic [15:0]              lfsr = 16'd46;
    logic [7:0]               main_bytes [8];
    int                       cycles = 0;

    tb_clock u_clock (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    sdram_model u_sdram (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .read_gap   ( read_gap   ),
        .sdram_ack  ( sdram_ack  ),
        .data_read  ( data_read  ),
        .data_rdy   ( data_rdy   )
    );

    rom_game_top i_dut (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .sdram_req   ( sdram_req   ),
        .sdram_ack   ( sdram_ack   ),
        .sdram_addr  ( sdram_addr  ),
        .data_read   ( data_read   ),
        .data_rdy    ( data_rdy    ),
        .main_cs     ( main_cs     ),
        .main_addr   ( main_addr   ),
        .main_ok     ( main_ok     ),
        .main_data   ( main_data   ),
        .scr_cs      ( scr_cs      ),
        .scr_addr    ( scr_addr    ),
        .scr_ok      ( scr_ok      ),
        .scr_data    ( scr_data    ),
        .obj_cs      ( obj_cs      ),
        .obj_addr    ( obj_addr    ),
        .obj_ok      ( obj_ok      ),
        .obj_data    ( obj_data    )
    );

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] value;
        logic       fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[6:0], fb};
        end
        return value;
    endfunction

    always @(posedge clk) begin
        read_gap <= 2'(random_bits(2));
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1);
        end
    end

    task automatic compare(input string test, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch in %s %s: expected %h, actual %h", test, what, exp, act);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string test, input string msg);
        $display("%s: %s", test, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Graphics regions have their low word address bits reordered
    function automatic rom_map_pkg::sdram_addr_t expected_prog_addr(input logic [24:0] addr);
        rom_map_pkg::sdram_addr_t base;
        base = addr[22:1];
        if (addr >= 25'(`SCR_START) && addr < 25'(`OBJ_START)) begin
            return {base[21:4], base[2:0], ~base[3]};
        end
        if (addr >= 25'(`OBJ_START) && addr < 25'(`PCM_START)) begin
            return {base[21:6], base[5], base[2:0], ~base[4], ~base[3]};
        end
        return base;
    endfunction

    function automatic logic [31:0] expected_line(input slot_pkg::slot_e slot,
                                                  input logic [14:0] line);
        logic [15:0] word;
        case (slot)
            slot_pkg::MAIN: word = 16'(line) << 1;
            slot_pkg::SCR:  word = 16'(`SCR_START >> 1) + (16'(line) << 1);
            default:        word = 16'(`OBJ_START >> 1) + (16'(line) << 1);
        endcase
        return {u_sdram.mem[word + 16'd1], u_sdram.mem[word]};
    endfunction

    function automatic logic [31:0] expected_data(input slot_pkg::slot_e slot,
                                                  input logic [14:0] addr);
        logic [31:0] line;
        if (slot != slot_pkg::MAIN) begin
            return expected_line(slot, addr);
        end
        line = expected_line(slot, addr >> 2);
        case (addr[1:0])
            2'd0:    return 32'(line[15:8]);
            2'd1:    return 32'(line[7:0]);
            2'd2:    return 32'(line[31:24]);
            default: return 32'(line[23:16]);
        endcase
    endfunction

    task automatic download_byte(input string test, input logic [24:0] addr,
                                 input logic [7:0] data);
        @(posedge clk);
        ioctl_addr <= addr;
        ioctl_dout <= data;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(posedge clk);
        assert (prog_we === 1'b1) else report_failure(test, "prog_we did not rise after ioctl_wr");
        compare(test, "prog_addr", 32'(expected_prog_addr(addr)), 32'(prog_addr));
        compare(test, "prog_mask", addr[0] ? 32'h2 : 32'h1, 32'(prog_mask));
        compare(test, "prog_data", 32'(data), 32'(prog_data));
        while (!sdram_ack) begin
            @(posedge clk);
            assert (prog_we === 1'b1) else report_failure(test, "prog_we fell before the ack");
        end
        @(posedge clk);
        assert (prog_we === 1'b0) else report_failure(test, "prog_we stayed high after the ack");
    endtask

    task automatic read_slot(input slot_pkg::slot_e slot, input logic [14:0] addr,
                             output logic [31:0] data, output logic req_seen);
        logic ok;
        @(posedge clk);
        case (slot)
            slot_pkg::MAIN: begin
                main_cs   <= 1'b1;
                main_addr <= addr;
            end
            slot_pkg::SCR: begin
                scr_cs   <= 1'b1;
                scr_addr <= addr[12:0];
            end
            default: begin
                obj_cs   <= 1'b1;
                obj_addr <= addr[13:0];
            end
        endcase
        ok       = 1'b0;
        req_seen = 1'b0;
        while (!ok) begin
            @(posedge clk);
            req_seen = req_seen | sdram_req;
            case (slot)
                slot_pkg::MAIN: begin
                    ok   = main_ok;
                    data = 32'(main_data);
                end
                slot_pkg::SCR: begin
                    ok   = scr_ok;
                    data = scr_data;
                end
                default: begin
                    ok   = obj_ok;
                    data = obj_data;
                end
            endcase
        end
        main_cs <= 1'b0;
        scr_cs  <= 1'b0;
        obj_cs  <= 1'b0;
    endtask

    task automatic read_check(input string test, input slot_pkg::slot_e slot,
                              input logic [14:0] addr, input logic expect_miss);
        logic [31:0] data;
        logic        req_seen;
        read_slot(slot, addr, data, req_seen);
        compare(test, "data", expected_data(slot, addr), data);
        compare(test, "sdram_req seen", 32'(expect_miss), 32'(req_seen));
    endtask

    task automatic test_reset();
        @(posedge clk);
        compare("reset", "prog_we", 0, 32'(prog_we));
        compare("reset", "sdram_req", 0, 32'(sdram_req));
        // Select every slot while downloading holds off the fills
        downloading <= 1'b1;
        main_cs     <= 1'b1;
        scr_cs      <= 1'b1;
        obj_cs      <= 1'b1;
        @(posedge clk);
        compare("reset", "main_ok", 0, 32'(main_ok));
        compare("reset", "scr_ok", 0, 32'(scr_ok));
        compare("reset", "obj_ok", 0, 32'(obj_ok));
        main_cs     <= 1'b0;
        scr_cs      <= 1'b0;
        obj_cs      <= 1'b0;
        downloading <= 1'b0;
    endtask

    task automatic test_main_download();
        @(posedge clk);
        downloading <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            main_bytes[i] = random_bits(8);
            download_byte("main_download", 25'h100 + 25'(i), main_bytes[i]);
        end
        @(posedge clk);
        downloading <= 1'b0;
    endtask

    task automatic test_gfx_download();
        @(posedge clk);
        downloading <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            download_byte("scr_download", 25'(`SCR_START) + 25'h30 + 25'(i * 5), random_bits(8));
        end
        for (int i = 0; i < 8; i++) begin
            download_byte("obj_download", 25'(`OBJ_START) + 25'h40 + 25'(i * 9), random_bits(8));
        end
        // Past the object region nothing is scrambled
        download_byte("other_download", 25'(`PCM_START) + 25'h21, random_bits(8));
        download_byte("other_download", 25'(`PCM_START) + 25'h06, random_bits(8));
        @(posedge clk);
        downloading <= 1'b0;
    endtask

    task automatic test_main_read();
        read_check("main_read", slot_pkg::MAIN, 15'h0102, 1'b1);
        read_check("main_read", slot_pkg::MAIN, 15'h0101, 1'b0);
        read_check("main_read", slot_pkg::MAIN, 15'h0107, 1'b1);
        read_check("main_read", slot_pkg::MAIN, 15'h4a5b, 1'b1);
    endtask

    task automatic test_gfx_read();
        logic [2:0] done;
        logic       req_checked;
        int         rank;
        read_check("gfx_read", slot_pkg::SCR, 15'h000c, 1'b1);
        read_check("gfx_read", slot_pkg::SCR, 15'h0010, 1'b1);
        read_check("gfx_read", slot_pkg::OBJ, 15'h0012, 1'b1);
        read_check("gfx_read", slot_pkg::OBJ, 15'h0019, 1'b1);
        // All three slots miss in the same cycle
        @(posedge clk);
        main_cs   <= 1'b1;
        main_addr <= 15'h0200;
        scr_cs    <= 1'b1;
        scr_addr  <= 13'h0123;
        obj_cs    <= 1'b1;
        obj_addr  <= 14'h0456;
        done        = 3'b000;
        req_checked = 1'b0;
        rank        = 0;
        while (done != 3'b111) begin
            @(posedge clk);
            if (sdram_req && !req_checked) begin
                compare("all_miss", "first sdram_addr", 32'h100, 32'(sdram_addr));
                req_checked = 1'b1;
            end
            if (main_ok && !done[slot_pkg::MAIN]) begin
                compare("all_miss", "main order", 0, rank);
                compare("all_miss", "main data", expected_data(slot_pkg::MAIN, 15'h0200),
                        32'(main_data));
                done[slot_pkg::MAIN] = 1'b1;
                rank++;
            end
            if (obj_ok && !done[slot_pkg::OBJ]) begin
                compare("all_miss", "obj order", 1, rank);
                compare("all_miss", "obj data", expected_data(slot_pkg::OBJ, 15'h0456), obj_data);
                done[slot_pkg::OBJ] = 1'b1;
                rank++;
            end
            if (scr_ok && !done[slot_pkg::SCR]) begin
                compare("all_miss", "scr order", 2, rank);
                compare("all_miss", "scr data", expected_data(slot_pkg::SCR, 15'h0123), scr_data);
                done[slot_pkg::SCR] = 1'b1;
                rank++;
            end
        end
        main_cs <= 1'b0;
        scr_cs  <= 1'b0;
        obj_cs  <= 1'b0;
    endtask

    task automatic test_invalidate();
        logic [7:0]  new_bytes [4];
        logic [31:0] data;
        logic        req_seen;
        read_slot(slot_pkg::MAIN, 15'h0100, data, req_seen);
        @(posedge clk);
        downloading <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            // Offset of 1 to 128 keeps every byte different from the old one
            new_bytes[i] = main_bytes[i] + 8'd1 + random_bits(7);
            download_byte("invalidate", 25'h100 + 25'(i), new_bytes[i]);
        end
        @(posedge clk);
        downloading <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            read_slot(slot_pkg::MAIN, 15'h0100 + 15'(i), data, req_seen);
            compare("invalidate", "new byte", 32'(new_bytes[i]), data);
            compare("invalidate", "refill request", 32'(i == 0), 32'(req_seen));
        end
    endtask

    initial begin
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        scr_cs      = 1'b0;
        scr_addr    = '0;
        obj_cs      = 1'b0;
        obj_addr    = '0;
        read_gap    = 2'd0;
        @(posedge rst_n);
        test_reset();
        test_main_download();
        test_gfx_download();
        test_main_read();
        test_gfx_read();
        test_invalidate();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/rom_map_pkg.sv
source/slot_pkg.sv
source/dwnld_remap.sv
source/slot_arbiter.sv
source/slot_cache.sv
source/rom_game_top.sv
dv/tb_clock.sv
dv/sdram_model.sv
dv/rom_game_tb.sv

//--- Bender.yml
package:
  name: rom_game

sources:
  - include_dirs:
      - source
    files:
      - source/rom_map_pkg.sv
      - source/slot_pkg.sv
      - source/dwnld_remap.sv
      - source/slot_arbiter.sv
      - source/slot_cache.sv
      - source/rom_game_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/tb_clock.sv
      - dv/sdram_model.sv
      - dv/rom_game_tb.sv
